// ==== mips_int_pipe.f ====
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/mips_decode.sv
hdl/mips_operand.sv
hdl/mips_regfile.sv
hdl/mips_execute.sv
hdl/mips_memory.sv
hdl/mips_int_pipe.sv
testbench/mips_int_pipe_checker.sv
testbench/tb_mips_int_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_int_pipe
FLIST     ?= mips_int_pipe.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_mips_int_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_int_pipe;

  localparam int DMEM_WORDS = 64;

  logic        clk;
  logic        rst_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        inst_ready_o;
  logic        wb_valid_o;
  logic [4:0]  wb_waddr_o;
  logic [31:0] wb_wdata_o;
  logic        branch_valid_o;
  logic [31:0] branch_target_o;

  logic [31:0] regs [32];
  logic [31:0] mem [DMEM_WORDS];
  logic [4:0]  exp_waddr [$];
  logic [31:0] exp_wdata [$];
  logic [31:0] exp_target [$];
  logic [31:0] lfsr;
  logic [31:0] pc;
  int          issued;
  int          cycles;
  int          stalls;

  mips_int_pipe #(.DMEM_WORDS(DMEM_WORDS)) dut0 (
    .clk(clk), .rst_i(rst_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i), .pc_i(pc_i),
    .inst_ready_o(inst_ready_o), .wb_valid_o(wb_valid_o), .wb_waddr_o(wb_waddr_o),
    .wb_wdata_o(wb_wdata_o), .branch_valid_o(branch_valid_o),
    .branch_target_o(branch_target_o)
  );

  always #10 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_msg(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] r_word(input logic [5:0] func, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
    return {mips_isa_pkg::R_OP, rs, rt, rd, sh, func};
  endfunction

  function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // sequential reference execution of one accepted word
  task automatic model_step(input logic [31:0] w, input logic [31:0] p);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] res;
    logic [31:0] p4;
    logic [4:0]  dest;
    logic        wr;
    a    = regs[w[25:21]];
    b    = regs[w[20:16]];
    se   = {{16{w[15]}}, w[15:0]};
    ze   = {16'h0, w[15:0]};
    p4   = p + 32'd4;
    dest = w[20:16];
    wr   = 1'b1;
    res  = '0;
    case (w[31:26])
      mips_isa_pkg::R_OP: begin
        dest = w[15:11];
        case (w[5:0])
          mips_isa_pkg::ADDU_FUNC, mips_isa_pkg::ADD_FUNC: res = a + b;
          mips_isa_pkg::SUBU_FUNC, mips_isa_pkg::SUB_FUNC: res = a - b;
          mips_isa_pkg::AND_FUNC:  res = a & b;
          mips_isa_pkg::OR_FUNC:   res = a | b;
          mips_isa_pkg::XOR_FUNC:  res = a ^ b;
          mips_isa_pkg::NOR_FUNC:  res = ~(a | b);
          mips_isa_pkg::SLT_FUNC:  res = {31'd0, $signed(a) < $signed(b)};
          mips_isa_pkg::SLTU_FUNC: res = {31'd0, a < b};
          mips_isa_pkg::SLL_FUNC:  res = b << w[10:6];
          mips_isa_pkg::SRL_FUNC:  res = b >> w[10:6];
          mips_isa_pkg::SRA_FUNC:  res = $signed(b) >>> w[10:6];
          default: wr = 1'b0;
        endcase
      end
      mips_isa_pkg::ADDIU_OP, mips_isa_pkg::ADDI_OP: res = a + se;
      mips_isa_pkg::SLTI_OP:  res = {31'd0, $signed(a) < $signed(se)};
      mips_isa_pkg::SLTIU_OP: res = {31'd0, a < se};
      mips_isa_pkg::ANDI_OP:  res = a & ze;
      mips_isa_pkg::ORI_OP:   res = a | ze;
      mips_isa_pkg::XORI_OP:  res = a ^ ze;
      mips_isa_pkg::LUI_OP:   res = {w[15:0], 16'h0};
      mips_isa_pkg::LW_OP:    res = mem[((a + se) >> 2) % DMEM_WORDS];
      mips_isa_pkg::SW_OP: begin
        mem[((a + se) >> 2) % DMEM_WORDS] = b;
        wr = 1'b0;
      end
      mips_isa_pkg::BEQ_OP: begin
        wr = 1'b0;
        if (a == b)
          exp_target.push_back(p + 32'd4 + (se << 2));
      end
      mips_isa_pkg::BNE_OP: begin
        wr = 1'b0;
        if (a != b)
          exp_target.push_back(p + 32'd4 + (se << 2));
      end
      mips_isa_pkg::J_OP: begin
        wr = 1'b0;
        exp_target.push_back({p4[31:28], w[25:0], 2'b00});
      end
      mips_isa_pkg::JAL_OP: begin
        exp_target.push_back({p4[31:28], w[25:0], 2'b00});
        dest = 5'd31;
        res  = p + 32'd8;
      end
      default: wr = 1'b0;
    endcase
    if (wr && dest != 5'd0) begin
      regs[dest] = res;
      exp_waddr.push_back(dest);
      exp_wdata.push_back(res);
    end
  endtask

  // called at a rising edge, returns at the acceptance edge
  task automatic issue(input logic [31:0] w);
    inst_valid_i <= 1'b1;
    inst_i       <= w;
    pc_i         <= pc;
    @(posedge clk);
    while (!inst_ready_o) begin
      stalls++;
      @(posedge clk);
    end
    model_step(w, pc);
    issued++;
    pc = pc + 32'd4;
  endtask

  task automatic drain();
    inst_valid_i <= 1'b0;
    while (exp_waddr.size() > 0 || exp_target.size() > 0)
      @(posedge clk);
    repeat (4) @(posedge clk); // catch stray events
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > 10 * issued + 200)
      fail_msg("timeout: pipeline did not finish in time");
    if (!rst_i && wb_valid_o) begin
      if (exp_waddr.size() == 0)
        fail_msg("unexpected write-back from the DUT");
      check_eq("wb_waddr_o", {27'd0, wb_waddr_o}, {27'd0, exp_waddr.pop_front()});
      check_eq("wb_wdata_o", wb_wdata_o, exp_wdata.pop_front());
    end
    if (!rst_i && branch_valid_o) begin
      if (exp_target.size() == 0)
        fail_msg("unexpected branch from the DUT");
      check_eq("branch_target_o", branch_target_o, exp_target.pop_front());
    end
  end

  task automatic immediate_ops();
    issue(i_word(mips_isa_pkg::ADDIU_OP, 5'd0, 5'd1, 16'hfff0));
    issue(i_word(mips_isa_pkg::ADDI_OP, 5'd1, 5'd2, 16'h8001));
    issue(i_word(mips_isa_pkg::SLTI_OP, 5'd1, 5'd3, 16'h0005));
    issue(i_word(mips_isa_pkg::SLTIU_OP, 5'd1, 5'd4, 16'hffff));
    issue(i_word(mips_isa_pkg::ANDI_OP, 5'd1, 5'd5, 16'hf0f3));
    issue(i_word(mips_isa_pkg::ORI_OP, 5'd0, 5'd6, 16'h9abc));
    issue(i_word(mips_isa_pkg::XORI_OP, 5'd1, 5'd7, 16'h8888));
    issue(i_word(mips_isa_pkg::LUI_OP, 5'd0, 5'd8, 16'hdead));
    drain();
  endtask

  task automatic forwarding_chain();
    issue(r_word(mips_isa_pkg::ADDU_FUNC, 5'd6, 5'd8, 5'd9, 5'd0));
    issue(r_word(mips_isa_pkg::SUBU_FUNC, 5'd9, 5'd1, 5'd10, 5'd0));
    issue(r_word(mips_isa_pkg::SLL_FUNC, 5'd0, 5'd10, 5'd11, 5'd3));
    issue(r_word(mips_isa_pkg::SRA_FUNC, 5'd0, 5'd11, 5'd12, 5'd2));
    issue(r_word(mips_isa_pkg::NOR_FUNC, 5'd12, 5'd9, 5'd13, 5'd0));
    issue(r_word(mips_isa_pkg::SLT_FUNC, 5'd13, 5'd10, 5'd14, 5'd0));
    issue(r_word(mips_isa_pkg::SRL_FUNC, 5'd0, 5'd13, 5'd15, 5'd7));
    issue(r_word(mips_isa_pkg::XOR_FUNC, 5'd15, 5'd14, 5'd16, 5'd0));
    drain();
  endtask

  task automatic store_load_stall();
    issue(i_word(mips_isa_pkg::ORI_OP, 5'd0, 5'd17, 16'h1234));
    issue(i_word(mips_isa_pkg::ADDIU_OP, 5'd0, 5'd18, 16'h0040));
    issue(i_word(mips_isa_pkg::SW_OP, 5'd18, 5'd17, 16'h0008));
    stalls = 0;
    issue(i_word(mips_isa_pkg::LW_OP, 5'd18, 5'd19, 16'h0008));
    issue(r_word(mips_isa_pkg::ADDU_FUNC, 5'd19, 5'd17, 5'd20, 5'd0));
    check_eq("load-use stall cycles", stalls, 32'd1);
    drain();
  endtask

  task automatic branches_and_jumps();
    issue(i_word(mips_isa_pkg::BEQ_OP, 5'd17, 5'd17, 16'h0010));
    issue(i_word(mips_isa_pkg::BNE_OP, 5'd17, 5'd17, 16'h0010));
    issue(i_word(mips_isa_pkg::BEQ_OP, 5'd17, 5'd20, 16'hfff8));
    issue(i_word(mips_isa_pkg::BNE_OP, 5'd17, 5'd20, 16'hfffc));
    issue({mips_isa_pkg::J_OP, 26'h0123456});
    issue({mips_isa_pkg::JAL_OP, 26'h2000040});
    drain();
  endtask

  task automatic random_mix();
    logic [31:0] kind;
    logic [31:0] sel;
    logic [31:0] rs;
    logic [31:0] rt;
    logic [31:0] rd;
    logic [31:0] imm;
    logic [5:0]  funcs [13];
    logic [5:0]  ops [8];
    funcs = '{mips_isa_pkg::ADDU_FUNC, mips_isa_pkg::ADD_FUNC, mips_isa_pkg::SUBU_FUNC,
              mips_isa_pkg::SUB_FUNC, mips_isa_pkg::AND_FUNC, mips_isa_pkg::OR_FUNC,
              mips_isa_pkg::XOR_FUNC, mips_isa_pkg::NOR_FUNC, mips_isa_pkg::SLT_FUNC,
              mips_isa_pkg::SLTU_FUNC, mips_isa_pkg::SLL_FUNC, mips_isa_pkg::SRL_FUNC,
              mips_isa_pkg::SRA_FUNC};
    ops = '{mips_isa_pkg::ADDIU_OP, mips_isa_pkg::ADDI_OP, mips_isa_pkg::SLTI_OP,
            mips_isa_pkg::SLTIU_OP, mips_isa_pkg::ANDI_OP, mips_isa_pkg::ORI_OP,
            mips_isa_pkg::XORI_OP, mips_isa_pkg::LUI_OP};
    for (int i = 0; i < 40; i++) begin
      rand_bits(1, kind);
      rand_bits(5, rs);
      rand_bits(5, rt);
      rand_bits(16, imm);
      if (kind[0]) begin
        rand_bits(4, sel);
        rand_bits(5, rd);
        issue(r_word(funcs[sel % 13], rs[4:0], rt[4:0], rd[4:0], imm[4:0]));
      end else begin
        rand_bits(3, sel);
        issue(i_word(ops[sel[2:0]], rs[4:0], rt[4:0], imm[15:0]));
      end
    end
    drain();
  endtask

  task automatic suppressed_writes();
    issue({6'h3f, 26'h3ffffff}); // unassigned opcode
    issue(i_word(mips_isa_pkg::ADDIU_OP, 5'd1, 5'd0, 16'h0005));
    issue(r_word(mips_isa_pkg::OR_FUNC, 5'd17, 5'd20, 5'd0, 5'd0));
    issue(r_word(6'h3e, 5'd17, 5'd20, 5'd21, 5'd0)); // unknown func
    drain();
  endtask

  initial begin
    clk          = 1'b0;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    lfsr         = 32'hb9f3;
    pc           = 32'h0040_0000;
    issued       = 0;
    cycles       = 0;
    stalls       = 0;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    immediate_ops();
    forwarding_chain();
    store_load_stall();
    branches_and_jumps();
    random_mix();
    suppressed_writes();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/mips_int_pipe_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_int_pipe_checker (
  input wire       clk,
  input wire       rst_i,
  input wire       inst_ready_o,
  input wire       wb_valid_o,
  input wire [4:0] wb_waddr_o,
  input wire       branch_valid_o
);

  // stall lasts one cycle only
  ready_low_once: assert property (@(posedge clk) disable iff (rst_i)
    !inst_ready_o |=> inst_ready_o)
    else $error("inst_ready_o low for two cycles");

  quiet_after_reset: assert property (@(posedge clk)
    rst_i |=> (!wb_valid_o && !branch_valid_o))
    else $error("valid output high right after reset");

  no_r0_write: assert property (@(posedge clk) disable iff (rst_i)
    wb_valid_o |-> (wb_waddr_o != 5'd0))
    else $error("write-back to r0");

endmodule

bind mips_int_pipe mips_int_pipe_checker checker0 (.*);

`default_nettype wire

// ==== hdl/mips_int_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_int_pipe #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic                                inst_valid_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      inst_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      pc_i,
  output logic                                inst_ready_o,
  output logic                                wb_valid_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0] wb_waddr_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      wb_wdata_o,
  output logic                                branch_valid_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      branch_target_o
);

  // decode to operand
  logic [mips_pipe_pkg::ALU_OP_W-1:0]  alu_op;
  logic                                rs_re;
  logic                                rt_re;
  logic                                we;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] rs_addr;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] rt_addr;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] waddr;
  logic [mips_pipe_pkg::XLEN-1:0]      imm;
  logic [mips_pipe_pkg::XLEN-1:0]      rs_data;
  logic [mips_pipe_pkg::XLEN-1:0]      rt_data;
  // ID/EX
  logic                                id_valid;
  logic [mips_pipe_pkg::ALU_OP_W-1:0]  id_alu_op;
  logic [mips_pipe_pkg::XLEN-1:0]      id_a;
  logic [mips_pipe_pkg::XLEN-1:0]      id_b;
  logic [mips_pipe_pkg::XLEN-1:0]      id_store;
  logic                                id_we;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] id_waddr;
  logic [mips_pipe_pkg::XLEN-1:0]      id_link;
  // forwarding and EX/MEM
  logic                                fwd_we;
  logic                                fwd_is_load;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] fwd_waddr;
  logic [mips_pipe_pkg::XLEN-1:0]      fwd_result;
  logic                                ex_we;
  logic                                ex_is_load;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] ex_waddr;
  logic [mips_pipe_pkg::XLEN-1:0]      ex_result;
  logic [mips_pipe_pkg::XLEN-1:0]      ex_store;
  logic                                ex_mem_we;
  logic                                mem_we;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] mem_waddr;
  logic [mips_pipe_pkg::XLEN-1:0]      mem_wdata;

  mips_decode u_decode (
    .inst_i(inst_i), .alu_op_o(alu_op), .rs_re_o(rs_re), .rt_re_o(rt_re), .we_o(we),
    .rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .waddr_o(waddr), .imm_o(imm)
  );

  mips_regfile u_regfile (
    .clk(clk), .rst_i(rst_i), .ra_i(rs_addr), .rb_i(rt_addr),
    .ra_data_o(rs_data), .rb_data_o(rt_data),
    .we_i(wb_valid_o), .waddr_i(wb_waddr_o), .wdata_i(wb_wdata_o)
  );

  mips_operand u_operand (
    .clk(clk), .rst_i(rst_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i), .pc_i(pc_i),
    .alu_op_i(alu_op), .rs_re_i(rs_re), .rt_re_i(rt_re), .we_i(we),
    .rs_addr_i(rs_addr), .rt_addr_i(rt_addr), .waddr_i(waddr), .imm_i(imm),
    .rs_data_i(rs_data), .rt_data_i(rt_data),
    .ex_we_i(fwd_we), .ex_is_load_i(fwd_is_load), .ex_waddr_i(fwd_waddr),
    .ex_result_i(fwd_result),
    .mem_we_i(mem_we), .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_wdata),
    .inst_ready_o(inst_ready_o), .id_valid_o(id_valid), .id_alu_op_o(id_alu_op),
    .id_a_o(id_a), .id_b_o(id_b), .id_store_o(id_store), .id_we_o(id_we),
    .id_waddr_o(id_waddr), .id_link_o(id_link),
    .branch_valid_o(branch_valid_o), .branch_target_o(branch_target_o)
  );

  mips_execute u_execute (
    .clk(clk), .rst_i(rst_i), .id_valid_i(id_valid), .id_alu_op_i(id_alu_op),
    .id_a_i(id_a), .id_b_i(id_b), .id_store_i(id_store), .id_we_i(id_we),
    .id_waddr_i(id_waddr), .id_link_i(id_link),
    .fwd_we_o(fwd_we), .fwd_is_load_o(fwd_is_load), .fwd_waddr_o(fwd_waddr),
    .fwd_result_o(fwd_result),
    .ex_we_o(ex_we), .ex_is_load_o(ex_is_load), .ex_waddr_o(ex_waddr),
    .ex_result_o(ex_result), .ex_store_o(ex_store), .ex_mem_we_o(ex_mem_we)
  );

  mips_memory #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
    .clk(clk), .rst_i(rst_i), .ex_we_i(ex_we), .ex_is_load_i(ex_is_load),
    .ex_waddr_i(ex_waddr), .ex_result_i(ex_result), .ex_store_i(ex_store),
    .ex_mem_we_i(ex_mem_we),
    .mem_we_o(mem_we), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata),
    .wb_valid_o(wb_valid_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o)
  );

endmodule

`default_nettype wire

// ==== hdl/mips_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_memory #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic                                ex_we_i,
  input  logic                                ex_is_load_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ex_waddr_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      ex_result_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      ex_store_i,
  input  logic                                ex_mem_we_i,
  output logic                                mem_we_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0] mem_waddr_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      mem_wdata_o,
  output logic                                wb_valid_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0] wb_waddr_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      wb_wdata_o
);

  logic [mips_pipe_pkg::XLEN-1:0] dmem [DMEM_WORDS];
  logic [$clog2(DMEM_WORDS)-1:0]  idx;

  assign idx = ex_result_i[$clog2(DMEM_WORDS)+1:2]; // word index wraps

  always_ff @(posedge clk) begin
    if (ex_mem_we_i)
      dmem[idx] <= ex_store_i;
  end

  assign mem_we_o    = ex_we_i;
  assign mem_waddr_o = ex_waddr_i;
  assign mem_wdata_o = ex_is_load_i ? dmem[idx] : ex_result_i;

  always_ff @(posedge clk) begin
    if (rst_i)
      wb_valid_o <= 1'b0;
    else
      wb_valid_o <= mem_we_o;
  end

  always_ff @(posedge clk) begin
    wb_waddr_o <= mem_waddr_o;
    wb_wdata_o <= mem_wdata_o;
  end

endmodule

`default_nettype wire

// ==== hdl/mips_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic                                id_valid_i,
  input  logic [mips_pipe_pkg::ALU_OP_W-1:0]  id_alu_op_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      id_a_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      id_b_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      id_store_i,
  input  logic                                id_we_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] id_waddr_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      id_link_i,
  output logic                                fwd_we_o,
  output logic                                fwd_is_load_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0] fwd_waddr_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      fwd_result_o,
  output logic                                ex_we_o,
  output logic                                ex_is_load_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0] ex_waddr_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      ex_result_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      ex_store_o,
  output logic                                ex_mem_we_o
);

  logic [mips_pipe_pkg::XLEN-1:0] alu;

  always_comb begin
    case (id_alu_op_i)
      mips_pipe_pkg::ALU_ADD,
      mips_pipe_pkg::ALU_LW,
      mips_pipe_pkg::ALU_SW:   alu = id_a_i + id_b_i; // loads and stores add too
      mips_pipe_pkg::ALU_SUB:  alu = id_a_i - id_b_i;
      mips_pipe_pkg::ALU_SLT:  alu = {31'd0, $signed(id_a_i) < $signed(id_b_i)};
      mips_pipe_pkg::ALU_SLTU: alu = {31'd0, id_a_i < id_b_i};
      mips_pipe_pkg::ALU_AND:  alu = id_a_i & id_b_i;
      mips_pipe_pkg::ALU_OR:   alu = id_a_i | id_b_i;
      mips_pipe_pkg::ALU_XOR:  alu = id_a_i ^ id_b_i;
      mips_pipe_pkg::ALU_NOR:  alu = ~(id_a_i | id_b_i);
      mips_pipe_pkg::ALU_SLL:  alu = id_b_i << id_a_i[4:0];
      mips_pipe_pkg::ALU_SRL:  alu = id_b_i >> id_a_i[4:0];
      mips_pipe_pkg::ALU_SRA:  alu = $signed(id_b_i) >>> id_a_i[4:0];
      mips_pipe_pkg::ALU_LINK: alu = id_link_i;
      default:                 alu = '0;
    endcase
  end

  // EX-stage view for forwarding
  assign fwd_we_o      = id_valid_i && id_we_i;
  assign fwd_is_load_o = id_valid_i && id_alu_op_i == mips_pipe_pkg::ALU_LW;
  assign fwd_waddr_o   = id_waddr_i;
  assign fwd_result_o  = alu;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_we_o      <= 1'b0;
      ex_is_load_o <= 1'b0;
      ex_mem_we_o  <= 1'b0;
    end else begin
      ex_we_o      <= fwd_we_o;
      ex_is_load_o <= fwd_is_load_o;
      ex_mem_we_o  <= id_valid_i && id_alu_op_i == mips_pipe_pkg::ALU_SW;
    end
  end

  always_ff @(posedge clk) begin
    ex_waddr_o  <= id_waddr_i;
    ex_result_o <= alu;
    ex_store_o  <= id_store_i;
  end

endmodule

`default_nettype wire

// ==== hdl/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ra_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] rb_i,
  output logic [mips_pipe_pkg::XLEN-1:0]      ra_data_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      rb_data_o,
  input  logic                                we_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      wdata_i
);

  logic [mips_pipe_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst_i)
      regs <= '{default: '0};
    else if (we_i && waddr_i != '0)
      regs[waddr_i] <= wdata_i;
  end

  // write-through covers the WB stage
  assign ra_data_o = (ra_i == '0) ? '0 : (we_i && waddr_i == ra_i) ? wdata_i : regs[ra_i];
  assign rb_data_o = (rb_i == '0) ? '0 : (we_i && waddr_i == rb_i) ? wdata_i : regs[rb_i];

endmodule

`default_nettype wire

// ==== hdl/mips_operand.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_operand (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic                                inst_valid_i,
  input  mips_isa_pkg::inst_u                 inst_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      pc_i,
  input  logic [mips_pipe_pkg::ALU_OP_W-1:0]  alu_op_i,
  input  logic                                rs_re_i,
  input  logic                                rt_re_i,
  input  logic                                we_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] rs_addr_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] rt_addr_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      imm_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      rs_data_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      rt_data_i,
  input  logic                                ex_we_i,
  input  logic                                ex_is_load_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ex_waddr_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      ex_result_i,
  input  logic                                mem_we_i,
  input  logic [mips_isa_pkg::REG_ADDR_W-1:0] mem_waddr_i,
  input  logic [mips_pipe_pkg::XLEN-1:0]      mem_wdata_i,
  output logic                                inst_ready_o,
  output logic                                id_valid_o,
  output logic [mips_pipe_pkg::ALU_OP_W-1:0]  id_alu_op_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      id_a_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      id_b_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      id_store_o,
  output logic                                id_we_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0] id_waddr_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      id_link_o,
  output logic                                branch_valid_o,
  output logic [mips_pipe_pkg::XLEN-1:0]      branch_target_o
);

  logic [mips_pipe_pkg::XLEN-1:0] rs_val;
  logic [mips_pipe_pkg::XLEN-1:0] rt_val;
  logic [mips_pipe_pkg::XLEN-1:0] pc4;
  logic [mips_pipe_pkg::XLEN-1:0] target;
  logic                           stall;
  logic                           accept;
  logic                           taken;

  // newest producer wins
  function automatic logic [mips_pipe_pkg::XLEN-1:0] fwd(
    input logic [mips_isa_pkg::REG_ADDR_W-1:0] addr,
    input logic [mips_pipe_pkg::XLEN-1:0]      rf_data
  );
    if (ex_we_i && ex_waddr_i == addr)
      return ex_result_i;
    else if (mem_we_i && mem_waddr_i == addr)
      return mem_wdata_i;
    return rf_data;
  endfunction

  always_comb begin
    rs_val = fwd(rs_addr_i, rs_data_i);
    rt_val = fwd(rt_addr_i, rt_data_i);
  end

  // load in EX cannot forward yet
  assign stall = ex_we_i && ex_is_load_i &&
                 ((rs_re_i && rs_addr_i == ex_waddr_i) || (rt_re_i && rt_addr_i == ex_waddr_i));
  assign inst_ready_o = !stall;
  assign accept       = inst_valid_i && !stall;
  assign pc4          = pc_i + 32'd4;

  always_comb begin
    taken  = 1'b0;
    target = pc4 + {{14{inst_i.i_fmt.imm16[15]}}, inst_i.i_fmt.imm16, 2'b00};
    case (inst_i.i_fmt.op)
      mips_isa_pkg::BEQ_OP: taken = (rs_val == rt_val);
      mips_isa_pkg::BNE_OP: taken = (rs_val != rt_val);
      mips_isa_pkg::J_OP, mips_isa_pkg::JAL_OP: begin
        taken  = 1'b1;
        target = {pc4[31:28], inst_i[25:0], 2'b00};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_valid_o     <= 1'b0;
      id_we_o        <= 1'b0;
      id_alu_op_o    <= mips_pipe_pkg::ALU_NOP;
      branch_valid_o <= 1'b0;
    end else begin
      id_valid_o     <= accept; // bubble when nothing is taken
      id_we_o        <= accept && we_i;
      id_alu_op_o    <= accept ? alu_op_i : mips_pipe_pkg::ALU_NOP;
      branch_valid_o <= accept && taken;
    end
  end

  always_ff @(posedge clk) begin
    id_a_o          <= rs_re_i ? rs_val : imm_i;
    id_b_o          <= (rt_re_i && alu_op_i != mips_pipe_pkg::ALU_SW) ? rt_val : imm_i;
    id_store_o      <= rt_val;
    id_waddr_o      <= waddr_i;
    id_link_o       <= pc4 + 32'd4;
    branch_target_o <= target;
  end

endmodule

`default_nettype wire

// ==== hdl/mips_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
  input  mips_isa_pkg::inst_u                     inst_i,
  output logic [mips_pipe_pkg::ALU_OP_W-1:0]      alu_op_o,
  output logic                                    rs_re_o,
  output logic                                    rt_re_o,
  output logic                                    we_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0]     rs_addr_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0]     rt_addr_o,
  output logic [mips_isa_pkg::REG_ADDR_W-1:0]     waddr_o,
  output logic [mips_pipe_pkg::XLEN-1:0]          imm_o
);

  logic [mips_pipe_pkg::XLEN-1:0] imm_s;
  logic [mips_pipe_pkg::XLEN-1:0] imm_z;
  logic                           we_raw;

  assign imm_s     = {{16{inst_i.i_fmt.imm16[15]}}, inst_i.i_fmt.imm16};
  assign imm_z     = {16'h0000, inst_i.i_fmt.imm16};
  assign rs_addr_o = inst_i.r_fmt.rs;
  assign rt_addr_o = inst_i.r_fmt.rt;
  assign we_o      = we_raw && (waddr_o != '0); // r0 writes are dropped

  always_comb begin
    alu_op_o = mips_pipe_pkg::ALU_NOP;
    rs_re_o  = 1'b0;
    rt_re_o  = 1'b0;
    we_raw   = 1'b0;
    waddr_o  = inst_i.i_fmt.rt;
    imm_o    = imm_s;
    case (inst_i.i_fmt.op)
      mips_isa_pkg::ADDIU_OP, mips_isa_pkg::ADDI_OP: begin
        alu_op_o = mips_pipe_pkg::ALU_ADD;
        rs_re_o  = 1'b1;
        we_raw   = 1'b1;
      end
      mips_isa_pkg::SLTI_OP: begin
        alu_op_o = mips_pipe_pkg::ALU_SLT;
        rs_re_o  = 1'b1;
        we_raw   = 1'b1;
      end
      mips_isa_pkg::SLTIU_OP: begin
        alu_op_o = mips_pipe_pkg::ALU_SLTU; // still sign-extended
        rs_re_o  = 1'b1;
        we_raw   = 1'b1;
      end
      mips_isa_pkg::ANDI_OP, mips_isa_pkg::ORI_OP, mips_isa_pkg::XORI_OP: begin
        alu_op_o = (inst_i.i_fmt.op == mips_isa_pkg::ANDI_OP) ? mips_pipe_pkg::ALU_AND :
                   (inst_i.i_fmt.op == mips_isa_pkg::ORI_OP)  ? mips_pipe_pkg::ALU_OR  :
                                                                mips_pipe_pkg::ALU_XOR;
        rs_re_o  = 1'b1;
        we_raw   = 1'b1;
        imm_o    = imm_z;
      end
      mips_isa_pkg::LUI_OP: begin
        alu_op_o = mips_pipe_pkg::ALU_OR; // both operands are the immediate
        we_raw   = 1'b1;
        imm_o    = {inst_i.i_fmt.imm16, 16'h0000};
      end
      mips_isa_pkg::LW_OP: begin
        alu_op_o = mips_pipe_pkg::ALU_LW;
        rs_re_o  = 1'b1;
        we_raw   = 1'b1;
      end
      mips_isa_pkg::SW_OP: begin
        alu_op_o = mips_pipe_pkg::ALU_SW;
        rs_re_o  = 1'b1;
        rt_re_o  = 1'b1;
      end
      mips_isa_pkg::BEQ_OP, mips_isa_pkg::BNE_OP: begin
        rs_re_o = 1'b1;
        rt_re_o = 1'b1;
      end
      mips_isa_pkg::JAL_OP: begin
        alu_op_o = mips_pipe_pkg::ALU_LINK;
        we_raw   = 1'b1;
        waddr_o  = mips_pipe_pkg::LINK_REG;
      end
      mips_isa_pkg::R_OP: begin
        waddr_o = inst_i.r_fmt.rd;
        rs_re_o = 1'b1;
        rt_re_o = 1'b1;
        we_raw  = 1'b1;
        case (inst_i.r_fmt.func)
          mips_isa_pkg::ADDU_FUNC, mips_isa_pkg::ADD_FUNC: alu_op_o = mips_pipe_pkg::ALU_ADD;
          mips_isa_pkg::SUBU_FUNC, mips_isa_pkg::SUB_FUNC: alu_op_o = mips_pipe_pkg::ALU_SUB;
          mips_isa_pkg::AND_FUNC:  alu_op_o = mips_pipe_pkg::ALU_AND;
          mips_isa_pkg::OR_FUNC:   alu_op_o = mips_pipe_pkg::ALU_OR;
          mips_isa_pkg::XOR_FUNC:  alu_op_o = mips_pipe_pkg::ALU_XOR;
          mips_isa_pkg::NOR_FUNC:  alu_op_o = mips_pipe_pkg::ALU_NOR;
          mips_isa_pkg::SLT_FUNC:  alu_op_o = mips_pipe_pkg::ALU_SLT;
          mips_isa_pkg::SLTU_FUNC: alu_op_o = mips_pipe_pkg::ALU_SLTU;
          mips_isa_pkg::SLL_FUNC, mips_isa_pkg::SRL_FUNC, mips_isa_pkg::SRA_FUNC: begin
            alu_op_o = (inst_i.r_fmt.func == mips_isa_pkg::SLL_FUNC) ? mips_pipe_pkg::ALU_SLL :
                       (inst_i.r_fmt.func == mips_isa_pkg::SRL_FUNC) ? mips_pipe_pkg::ALU_SRL :
                                                                       mips_pipe_pkg::ALU_SRA;
            rs_re_o  = 1'b0; // shamt takes the rs slot
            imm_o    = {27'd0, inst_i.r_fmt.shamt};
          end
          default: begin
            rs_re_o = 1'b0;
            rt_re_o = 1'b0;
            we_raw  = 1'b0;
          end
        endcase
      end
      default: ; // J and unknown words do nothing here
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/mips_pipe_pkg.sv ====
`default_nettype none

package mips_pipe_pkg;

  localparam int XLEN     = 32;
  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_NOP  = 4'h0;
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'h1;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'h2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'h3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'h4;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'h5;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'h6;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'h7;
  localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'h8;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'h9;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'ha;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'hb;
  localparam logic [ALU_OP_W-1:0] ALU_LINK = 4'hc; // pass link value
  localparam logic [ALU_OP_W-1:0] ALU_LW   = 4'hd;
  localparam logic [ALU_OP_W-1:0] ALU_SW   = 4'he;

  localparam logic [mips_isa_pkg::REG_ADDR_W-1:0] LINK_REG = 5'd31;

endpackage

`default_nettype wire

// ==== hdl/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

  localparam int REG_ADDR_W = 5;

  // major opcodes
  localparam logic [5:0] R_OP     = 6'h00;
  localparam logic [5:0] J_OP     = 6'h02;
  localparam logic [5:0] JAL_OP   = 6'h03;
  localparam logic [5:0] BEQ_OP   = 6'h04;
  localparam logic [5:0] BNE_OP   = 6'h05;
  localparam logic [5:0] ADDI_OP  = 6'h08;
  localparam logic [5:0] ADDIU_OP = 6'h09;
  localparam logic [5:0] SLTI_OP  = 6'h0a;
  localparam logic [5:0] SLTIU_OP = 6'h0b;
  localparam logic [5:0] ANDI_OP  = 6'h0c;
  localparam logic [5:0] ORI_OP   = 6'h0d;
  localparam logic [5:0] XORI_OP  = 6'h0e;
  localparam logic [5:0] LUI_OP   = 6'h0f;
  localparam logic [5:0] LW_OP    = 6'h23;
  localparam logic [5:0] SW_OP    = 6'h2b;

  // func field of R_OP
  localparam logic [5:0] SLL_FUNC  = 6'h00;
  localparam logic [5:0] SRL_FUNC  = 6'h02;
  localparam logic [5:0] SRA_FUNC  = 6'h03;
  localparam logic [5:0] ADD_FUNC  = 6'h20;
  localparam logic [5:0] ADDU_FUNC = 6'h21;
  localparam logic [5:0] SUB_FUNC  = 6'h22;
  localparam logic [5:0] SUBU_FUNC = 6'h23;
  localparam logic [5:0] AND_FUNC  = 6'h24;
  localparam logic [5:0] OR_FUNC   = 6'h25;
  localparam logic [5:0] XOR_FUNC  = 6'h26;
  localparam logic [5:0] NOR_FUNC  = 6'h27;
  localparam logic [5:0] SLT_FUNC  = 6'h2a;
  localparam logic [5:0] SLTU_FUNC = 6'h2b;

  typedef struct packed {
    logic [5:0]            op;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            shamt;
    logic [5:0]            func;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]            op;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [15:0]           imm16;
  } i_fmt_t;

  // same 32 bits, two field layouts
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

endpackage

`default_nettype wire
